// File: verilog/isa_pkg.sv
`default_nettype none

// instruction set encoding of the 16-bit serial cpu as seen by the decoder
package isa_pkg;

	// register index, top bit set selects a special register
	localparam int NR_BITS = 4;

	// special register 0 is the stack pointer
	localparam logic [NR_BITS-1:0] REG_SP = 4'b1000;

	// condition code that turns a branch into a call
	localparam logic [3:0] CC_CALL = 4'd15;

	// {m, d, z} patterns of the general format
	// 100 (r, s)  101 (r, imm6)  110 (d, r)  111 (d, r)b / shift
	// 00x (r, zp)  01x (zp, r)
	localparam logic [2:0] MDZ_IMM6  = 3'b101;
	localparam logic [2:0] MDZ_SHIFT = 3'b111;

	// aaa of the alu group that means cmp (d=0) or test (d=1)
	localparam logic [2:0] AAA_CMPTEST = 3'b111;

	// shift_op value for shl
	localparam logic [2:0] SHIFT_SHL = 3'b110;

	// general format
	// 1eaaamrrdziiiiii  r8 binop/shift
	// 01aaamrrdziiiiii  r16 binop/shift
	// 001gomrrdziiiiii  r8 mov/shift/swap
	// 0001omrrdziiiiii  r16 mov/shift/swap
	typedef struct packed {
		logic       b8;
		logic       e;
		logic [2:0] aaa;
		logic       m;
		logic [1:0] rr;
		logic       d;
		logic       z;
		logic [5:0] imm6;
	} inst_gen_t;

	// branch format
	// 0000ccccbbbbbbbb
	typedef struct packed {
		logic [3:0] prefix;
		logic [3:0] cccc;
		logic [7:0] disp8;
	} inst_br_t;

	// one instruction word, read through either format
	typedef union packed {
		inst_gen_t gen;
		inst_br_t  br;
	} inst_u;

	// jumps are carried by the mov class
	typedef enum logic [1:0] {
		class_alu,
		class_mov,
		class_swap,
		class_shift
	} inst_class_e;

endpackage

`default_nettype wire

// File: verilog/uop_pkg.sv
`default_nettype none

// micro-operation control word and the stage records passed down the decoder
package uop_pkg;
	import isa_pkg::*;

	// bit 2 clear means an add-type op that drives the carry
	localparam int OP_BIT_NADD = 2;

	typedef enum logic [2:0] {
		op_add, op_sub, op_adc, op_sbc,
		op_and, op_or, op_xor, op_mov
	} op_e;

	typedef enum logic [2:0] {
		src_reg, src_mem, src_imm2, src_imm6, src_imm7, src_imm8, src_imm16
	} src_e;

	typedef enum logic [1:0] {dest_reg, dest_mem, dest_pc, dest_imm8} dest_e;

	typedef enum logic {addr_add, addr_mov} addr_op_e;

	// class decode result
	typedef struct packed {
		inst_class_e        cls;
		logic               wide;
		logic [NR_BITS-1:0] r;
		logic [2:0]         shift_op;
		logic               use_zp, use_imm8, branch, jump, src1_from_pc;
		logic               cmptest, alt_op_available, effective_d, pre_step;
		inst_u              inst;
	} class_info_t;

	// second operand decode result
	typedef struct packed {
		class_info_t        cls_info;
		src_e               src;
		logic               wide2, src_sext2;
		src_e               addr_src;
		addr_op_e           addr_op;
		logic [NR_BITS-1:0] addr_reg1, addr_reg2;
		logic               addr_src_sext2;
		logic               autoincdec, autoincdec_dir, autoincdec_update;
		logic [NR_BITS-1:0] arg2_reg;
		logic               arg2_pure_reg, no_flag_updates, long_inst;
	} operand_info_t;

	// decoded micro-operation
	typedef struct packed {
		op_e                op;
		dest_e              dest;
		src_e               src;
		logic [NR_BITS-1:0] reg_dest, reg_src;
		logic               wide, wide2, src_sext2, src1_from_pc, src1_zero;
		addr_op_e           addr_op;
		src_e               addr_src;
		logic [NR_BITS-1:0] addr_reg1, addr_reg2;
		logic               addr_wide2, autoincdec, addr_just_reg1;
		logic [1:0]         imm2_value;
		logic               update_dest, force_reverse_args, invert_src2;
		logic               update_carry_flags, update_other_flags, no_flag_updates;
		logic               use_cc;
		logic [3:0]         cc;
		logic               use_rotate, rotate_only, use_shr, use_sar, use_shl;
		logic [3:0]         rotate_count;
		logic               do_swap, pre_step;
	} uop_t;

endpackage

`default_nettype wire

// File: verilog/inst_issue.sv
`timescale 1ns/10ps
`default_nettype none

// issue stage, takes instruction words and splits calls into a push step and a jump step
module inst_issue import isa_pkg::*; (
	input  logic  clk,
	input  logic  rst_n,
	input  logic  inst_valid,
	input  inst_u inst,
	output logic  inst_done,
	output logic  issue_valid,
	output inst_u issue_word,
	output logic  issue_pre
);
	// set after the push step went out, cleared when the jump goes
	logic step;
	logic branch_call;
	logic jump_call;
	logic pre;

	// 0000 1111 disp8
	assign branch_call = (inst.br.prefix == 4'b0000) && (inst.br.cccc == CC_CALL);

	// 0010000001iiiiii, call src
	assign jump_call = !inst.gen.b8 && !inst.gen.e && (inst.gen.aaa == 3'b100) &&
		!inst.gen.m && (inst.gen.rr == 2'b00) && !inst.gen.d && inst.gen.z;

	// push pc+n first, the word stays at the input
	assign pre = inst_valid && (branch_call || jump_call) && !step;

	// word is consumed only by the main step
	assign inst_done = inst_valid && !pre;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			step <= 1'b0;
			issue_valid <= 1'b0;
			issue_pre <= 1'b0;
		end else begin
			if (inst_done) begin
				step <= 1'b0;
			end else if (pre) begin
				step <= 1'b1;
			end
			// one step per valid cycle
			issue_valid <= inst_valid;
			issue_pre <= pre;
		end
	end

	always_ff @(posedge clk) begin
		if (inst_valid) begin
			issue_word <= inst;
		end
	end

	// the jump step decodes the same call word as the push step
	a_call_word_held: assert property (
		@(posedge clk) disable iff (!rst_n) pre |=> inst_valid && $stable(inst)
	);

	// relies on the source holding the call word until inst_done
	a_step_single: assert property (
		@(posedge clk) disable iff (!rst_n) step |=> !step
	);

endmodule

`default_nettype wire

// File: verilog/class_decode.sv
`timescale 1ns/10ps
`default_nettype none

// class decode stage, splits the word into fields and finds class, width and jump info
module class_decode import isa_pkg::*, uop_pkg::*; (
	input  logic        clk,
	input  logic        rst_n,
	input  logic        issue_valid,
	input  inst_u       issue_word,
	input  logic        issue_pre,
	output logic        cls_valid,
	output class_info_t cls_info
);
	inst_gen_t   g;
	logic [2:0]  mdz;
	class_info_t info;

	assign g = issue_word.gen;
	assign mdz = {g.m, g.d, g.z};

	always_comb begin
		info = '0;
		info.inst = issue_word;
		info.pre_step = issue_pre;
		info.cls = class_mov;
		info.use_zp = !g.m;
		info.effective_d = g.d;

		if (g.b8 || g.e) begin
			// binop / shift group
			info.wide = !g.b8;
			info.cls = (mdz == MDZ_SHIFT) ? class_shift : class_alu;
			// odd byte register only in the r8 form
			info.r = {1'b0, g.rr, g.e & g.b8};
			info.shift_op = g.aaa;
			info.cmptest = (g.aaa == AAA_CMPTEST);
			info.alt_op_available = !info.cmptest && (mdz != MDZ_SHIFT);
			// shifts and cmp/test never write back through d
			if (info.cmptest || mdz == MDZ_SHIFT) begin
				info.effective_d = 1'b0;
			end
		end else if (g.aaa[2] || g.aaa[1]) begin
			// mov/swap/shift group
			info.wide = !g.aaa[2];
			info.r = {1'b0, g.rr, g.aaa[1] & g.aaa[2]};
			// imm6[3:0] holds the shift count
			info.shift_op = {g.imm6[5:4], 1'b0};
			if (!g.aaa[0]) begin
				// mov r, imm8
				if (g.m) begin
					info.use_imm8 = 1'b1;
					info.effective_d = 1'b0;
				end
				// jumps sit on rr=0, other rr are left as plain moves
				if (!g.m && !g.d && g.rr == 2'b00) begin
					info.jump = !issue_pre;
					if (!info.wide) begin
						// jump/call src, target is always 16 bits
						info.wide = 1'b1;
						info.use_zp = 1'b0;
						// push step adds to pc
						info.src1_from_pc = issue_pre;
					end
				end
				if (!g.m && g.d) begin
					info.cls = class_swap;
				end
			end else begin
				// odd group, shift on (r, imm6), swap on (d, r)b
				if (mdz == MDZ_IMM6) begin
					info.cls = class_shift;
				end
				if (mdz == MDZ_SHIFT) begin
					info.cls = class_swap;
				end
				info.alt_op_available = (info.cls == class_mov);
			end
		end else begin
			// branch, pc + sext disp8
			info.wide = 1'b1;
			info.branch = 1'b1;
			info.src1_from_pc = 1'b1;
			info.use_imm8 = 1'b1;
			info.effective_d = 1'b0;
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			cls_valid <= 1'b0;
		end else begin
			cls_valid <= issue_valid;
		end
	end

	always_ff @(posedge clk) begin
		cls_info <= info;
	end

endmodule

`default_nettype wire

// File: verilog/operand_decode.sv
`timescale 1ns/10ps
`default_nettype none

// operand decode stage, turns the second-operand mode into source and address controls
module operand_decode import isa_pkg::*, uop_pkg::*; (
	input  logic          clk,
	input  logic          rst_n,
	input  logic          cls_valid,
	input  class_info_t   cls_info,
	output logic          opd_valid,
	output operand_info_t opd_info
);
	inst_gen_t     g;
	logic [2:0]    mdz;
	logic          push;
	operand_info_t o;

	assign g = cls_info.inst.gen;
	assign mdz = {g.m, g.d, g.z};
	// push pc+n step
	assign push = cls_info.pre_step;

	always_comb begin
		o = '0;
		o.cls_info = cls_info;
		o.src = src_reg;
		o.addr_src = src_reg;
		o.addr_op = addr_add;
		o.wide2 = cls_info.wide;
		o.arg2_reg = {1'b0, g.imm6[2:0]};
		o.addr_reg2 = {1'b0, g.imm6[2:0]};
		// imm16 or [imm16]
		o.long_inst = !cls_info.branch && (g.imm6[5:2] == 4'b0000) && g.imm6[0];

		if (cls_info.use_imm8 && !push) begin
			o.src = src_imm8;
			o.wide2 = 1'b0;
			o.src_sext2 = 1'b1;
		end else if (cls_info.use_zp && !push) begin
			// zero page
			o.src = src_mem;
			o.addr_op = addr_mov;
			o.addr_src = src_imm7;
		end else if (mdz == MDZ_IMM6 && !push) begin
			o.src = src_imm6;
			o.wide2 = 1'b0;
			o.src_sext2 = 1'b1;
		end else if (g.imm6[5] || push) begin
			// 1RRrrr [r16 + r8], push goes through here as [--sp]
			o.src = push ? src_imm2 : src_mem;
			o.addr_reg1 = push ? REG_SP : {1'b0, g.imm6[4:3], 1'b0};
			// r8 inside the base pair means auto inc/dec instead
			o.autoincdec = (o.addr_reg1[2:1] == o.addr_reg2[2:1]) || push;
			o.autoincdec_update = o.autoincdec;
			// 1 = decrement
			o.autoincdec_dir = g.imm6[0] || push;
			o.addr_src = o.autoincdec ? src_imm2 : src_reg;
			o.addr_src_sext2 = o.autoincdec;
		end else if (g.imm6[4]) begin
			// 01RRii [r16 + imm2]
			o.src = src_mem;
			o.addr_reg1 = {1'b0, g.imm6[3:2], 1'b0};
			o.addr_src = src_imm2;
		end else if (g.imm6[3] || !g.imm6[0]) begin
			o.src = src_reg;
			if (!cls_info.wide && !g.imm6[3]) begin
				// 000rr0 special register in byte ops
				o.arg2_reg[NR_BITS-1] = 1'b1;
				// writing a special reg, flags included, leaves flags alone
				o.no_flag_updates = cls_info.effective_d;
			end else begin
				// 001rrr r8, 000rr0 r16
				o.wide2 = !g.imm6[3];
				// d picks sign or zero extension
				o.src_sext2 = !g.d || cls_info.cmptest;
				o.arg2_pure_reg = !cls_info.wide || !g.imm6[3];
			end
		end else begin
			// 000xy1
			case (g.imm6[2:1])
				2'd0: begin
					o.src = src_imm16;
				end
				2'd1: begin
					// [imm16]
					o.src = src_mem;
					o.addr_src = src_imm16;
					o.addr_op = addr_mov;
				end
				2'd2: begin
					// push/pop/[sp]
					o.src = src_mem;
					o.addr_src = src_imm2;
					o.addr_reg1 = REG_SP;
					o.addr_src_sext2 = 1'b1;
					o.autoincdec = 1'b1;
					// rmw ops just touch [sp] and leave sp as is
					o.autoincdec_update = (cls_info.cls == class_mov) || !cls_info.effective_d;
					o.autoincdec_dir = cls_info.effective_d && o.autoincdec_update;
				end
				default: begin
					o.src = src_reg;
					o.arg2_reg = REG_SP;
				end
			endcase
		end
		// rotate keeps the width of the destination
		if (cls_info.cls == class_shift) begin
			o.wide2 = cls_info.wide;
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			opd_valid <= 1'b0;
		end else begin
			opd_valid <= cls_valid;
		end
	end

	always_ff @(posedge clk) begin
		opd_info <= o;
	end

	// branch target is always pc + disp8, never an inline word
	a_branch_no_imm16: assert property (
		@(posedge clk) disable iff (!rst_n)
		opd_valid && opd_info.cls_info.branch |-> opd_info.src != src_imm16
	);

endmodule

`default_nettype wire

// File: verilog/uop_build.sv
`timescale 1ns/10ps
`default_nettype none

// micro-op build stage, picks op, destination, swap, flags and shift controls
module uop_build import isa_pkg::*, uop_pkg::*; (
	input  logic          clk,
	input  logic          rst_n,
	input  logic          opd_valid,
	input  operand_info_t opd_info,
	output logic          uop_valid,
	output uop_t          uop
);
	class_info_t ci;
	inst_gen_t   g;
	op_e         binop;
	logic        cmp, test, special_reg2, use_alt_op, sub_or_sbc, swap_args;
	logic        use_rotate, use_shr, use_sar, use_shl, use_rol, rcount_msb_mask;
	uop_t        u;

	assign ci = opd_info.cls_info;
	assign g = ci.inst.gen;
	assign binop = op_e'(g.aaa);

	assign cmp = ci.cmptest && !g.d;
	assign test = ci.cmptest && g.d;
	assign special_reg2 = opd_info.arg2_reg[NR_BITS-1];
	// alternate op only between plain registers written through d
	assign use_alt_op = ci.alt_op_available && !special_reg2 && opd_info.arg2_pure_reg && g.d;
	assign sub_or_sbc = (ci.cls == class_alu) && (binop == op_sub || binop == op_sbc);
	// both args are registers here
	assign swap_args = special_reg2 && ci.effective_d && (ci.cls != class_shift);

	// shift decode
	assign use_rotate = (ci.cls == class_shift);
	assign use_shr = (ci.shift_op[2:1] == 2'b10);
	assign use_sar = (ci.shift_op[2:1] == 2'b01);
	assign use_shl = (ci.shift_op == SHIFT_SHL);
	assign use_rol = use_rotate && (ci.shift_op[0] || use_shl);
	// sar/shr may shift a byte by 8 or more to get pure sign/zero
	assign rcount_msb_mask = !(use_rotate && !ci.wide && !(use_sar || use_shr));

	always_comb begin
		u = '0;
		if (ci.branch || ci.src1_from_pc) begin
			u.op = op_add;
		end else if (use_rol || cmp) begin
			u.op = op_sub;
		end else if (test) begin
			u.op = op_and;
		end else begin
			u.op = (ci.cls == class_alu) ? binop : op_mov;
		end

		if ((ci.branch || ci.jump) && !ci.pre_step) begin
			u.dest = dest_pc;
		end else if (use_rotate) begin
			u.dest = dest_imm8;
		end else if ((ci.effective_d && opd_info.src == src_mem) || ci.pre_step) begin
			u.dest = dest_mem;
		end else begin
			u.dest = dest_reg;
		end

		u.src = opd_info.src;
		u.reg_dest = swap_args ? opd_info.arg2_reg : ci.r;
		u.reg_src = swap_args ? ci.r : opd_info.arg2_reg;
		u.wide = ci.wide;
		u.wide2 = opd_info.wide2;
		u.src_sext2 = opd_info.src_sext2;
		u.src1_from_pc = ci.src1_from_pc;
		// rol runs as 0 - x through the rotator
		u.src1_zero = use_rol;

		u.addr_op = opd_info.addr_op;
		u.addr_src = opd_info.addr_src;
		u.addr_reg1 = opd_info.addr_reg1;
		u.addr_reg2 = opd_info.addr_reg2;
		u.addr_wide2 = (opd_info.addr_src == src_imm16);
		u.autoincdec = opd_info.autoincdec_update;
		// post-increment reads the unmodified pointer
		u.addr_just_reg1 = opd_info.autoincdec && !opd_info.autoincdec_dir;
		// pc words to step over for the pushed return address
		u.imm2_value = opd_info.long_inst ? 2'd2 : 2'd1;

		u.update_dest = !ci.cmptest;
		// sub r, imm6 and the alternate sub run reversed
		u.force_reverse_args = sub_or_sbc && ({g.m, g.d, g.z} == MDZ_IMM6 || use_alt_op);
		u.invert_src2 = use_alt_op && !sub_or_sbc;
		u.update_carry_flags = (ci.cls == class_alu) && (cmp || !binop[OP_BIT_NADD]);
		u.update_other_flags = (ci.cls == class_alu);
		u.no_flag_updates = opd_info.no_flag_updates;

		u.use_cc = ci.branch;
		u.cc = ci.inst.br.cccc;

		u.use_rotate = use_rotate;
		// d=0 is the plain rotate form
		u.rotate_only = use_rotate && !g.d;
		u.use_shr = use_shr;
		u.use_sar = use_sar;
		u.use_shl = use_shl;
		u.rotate_count = {g.imm6[3] & rcount_msb_mask, g.imm6[2:0]};

		u.do_swap = (ci.cls == class_swap);
		u.pre_step = ci.pre_step;
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			uop_valid <= 1'b0;
		end else begin
			uop_valid <= opd_valid;
		end
	end

	always_ff @(posedge clk) begin
		uop <= u;
	end

endmodule

`default_nettype wire

// File: verilog/inst_decoder.sv
`timescale 1ns/10ps
`default_nettype none

// four-stage pipelined instruction decoder, one micro-op per cycle
module inst_decoder import isa_pkg::*, uop_pkg::*; (
	input  logic  clk,
	input  logic  rst_n,
	input  logic  inst_valid,
	input  inst_u inst,
	output logic  inst_done,
	output logic  uop_valid,
	output uop_t  uop
);
	// issue -> class decode
	logic          issue_valid;
	inst_u         issue_word;
	logic          issue_pre;
	// class decode -> operand decode
	logic          cls_valid;
	class_info_t   cls_info;
	// operand decode -> build
	logic          opd_valid;
	operand_info_t opd_info;

	inst_issue u_issue (
		.clk(clk), .rst_n(rst_n),
		.inst_valid(inst_valid), .inst(inst), .inst_done(inst_done),
		.issue_valid(issue_valid), .issue_word(issue_word), .issue_pre(issue_pre)
	);

	class_decode u_class (
		.clk(clk), .rst_n(rst_n),
		.issue_valid(issue_valid), .issue_word(issue_word), .issue_pre(issue_pre),
		.cls_valid(cls_valid), .cls_info(cls_info)
	);

	operand_decode u_operand (
		.clk(clk), .rst_n(rst_n),
		.cls_valid(cls_valid), .cls_info(cls_info),
		.opd_valid(opd_valid), .opd_info(opd_info)
	);

	uop_build u_build (
		.clk(clk), .rst_n(rst_n),
		.opd_valid(opd_valid), .opd_info(opd_info),
		.uop_valid(uop_valid), .uop(uop)
	);

endmodule

`default_nettype wire

// File: tests/decode_vectors.svh
// decode table, instruction words and the micro-ops expected for each of them

task automatic load_vectors();
	// branch, cc 3
	add_row(16'h0310, 1);
	start_uop(op_add, dest_pc, src_imm8, 1'b0);
	cur_exp.use_cc = 1'b1;
	cur_care.use_cc = 1'b1;
	cur_exp.cc = 4'd3;
	cur_care.cc = 4'hf;
	cur_exp.src1_from_pc = 1'b1;
	cur_care.src1_from_pc = 1'b1;
	end_uop();
	// call through the branch format, push then jump
	add_row(16'h0F05, 2);
	push_uop(2'd1);
	start_uop(op_add, dest_pc, src_imm8, 1'b0);
	cur_exp.use_cc = 1'b1;
	cur_care.use_cc = 1'b1;
	cur_exp.cc = 4'd15;
	cur_care.cc = 4'hf;
	end_uop();
	// call r3, short instruction
	add_row(16'h204B, 2);
	push_uop(2'd1);
	start_uop(op_mov, dest_pc, src_reg, 1'b0);
	cur_exp.reg_src = 4'd3;
	cur_care.reg_src = 4'hf;
	end_uop();
	// call imm16, return address two words on
	add_row(16'h2041, 2);
	push_uop(2'd2);
	start_uop(op_mov, dest_pc, src_imm16, 1'b0);
	end_uop();
	// add r2, r5
	add_row(16'h850D, 1);
	start_uop(op_add, dest_reg, src_reg, 1'b0);
	cur_exp.reg_dest = 4'd2;
	cur_care.reg_dest = 4'hf;
	cur_exp.reg_src = 4'd5;
	cur_care.reg_src = 4'hf;
	cur_exp.update_dest = 1'b1;
	cur_care.update_dest = 1'b1;
	end_uop();
	// cmp r2, r5
	add_row(16'hBD0D, 1);
	start_uop(op_sub, dest_reg, src_reg, 1'b0);
	cur_care.update_dest = 1'b1;
	cur_exp.update_carry_flags = 1'b1;
	cur_care.update_carry_flags = 1'b1;
	end_uop();
	// test r2, r5
	add_row(16'hBD8D, 1);
	start_uop(op_and, dest_reg, src_reg, 1'b0);
	cur_care.update_dest = 1'b1;
	end_uop();
	// operand modes: imm6, zero page, imm16, [imm16]
	add_row(16'h8555, 1);
	start_uop(op_add, dest_reg, src_imm6, 1'b0);
	end_uop();
	add_row(16'h8107, 1);
	start_uop(op_add, dest_reg, src_mem, 1'b0);
	expect_addr(src_imm7, addr_mov);
	end_uop();
	add_row(16'h8501, 1);
	start_uop(op_add, dest_reg, src_imm16, 1'b0);
	end_uop();
	add_row(16'h8503, 1);
	start_uop(op_add, dest_reg, src_mem, 1'b0);
	expect_addr(src_imm16, addr_mov);
	end_uop();
	// shr byte by 11, sar keeps count bit 3
	add_row(16'hA5CB, 1);
	start_uop(op_mov, dest_imm8, src_reg, 1'b0);
	expect_shift(1'b1, 1'b0, 1'b0, 4'd11);
	end_uop();
	// shl byte, count bit 3 masked
	add_row(16'hB5CA, 1);
	start_uop(op_sub, dest_imm8, src_reg, 1'b0);
	expect_shift(1'b0, 1'b0, 1'b1, 4'd2);
	end_uop();
	// word sar by 9
	add_row(16'h5DC9, 1);
	start_uop(op_sub, dest_imm8, src_reg, 1'b0);
	expect_shift(1'b0, 1'b1, 1'b0, 4'd9);
	end_uop();
endtask

// File: tests/tb_inst_decoder.sv
// testbench for the pipelined instruction decoder, table driven with an in-order checker
`timescale 1ns/10ps
`default_nettype none

module tb_inst_decoder import isa_pkg::*, uop_pkg::*; ();
	localparam int CLK_PERIOD = 20;
	localparam int ROW_CYCLES = 10;
	localparam int UOP_LATENCY = 4;

	logic  clk;
	logic  rst_n;
	logic  inst_valid;
	inst_u inst;
	logic  inst_done;
	logic  uop_valid;
	uop_t  uop;

	// decode table, flat uop list indexed through vec_first
	logic [15:0] vec_word[$];
	int          vec_nuop[$];
	int          vec_first[$];
	uop_t        flat_exp[$];
	uop_t        flat_care[$];
	uop_t        cur_exp;
	uop_t        cur_care;

	// expected stream seen by the collector
	uop_t exp_q[$];
	uop_t care_q[$];
	// cycle in which each issued uop must come out
	int   due_q[$];

	int         uop_errs;
	int         count_errs;
	int         stream_errs;
	int         done_count;
	int         done_expected;
	int         cyc_count;
	logic [7:0] lfsr;

	inst_decoder DUT (
		.clk(clk),
		.rst_n(rst_n),
		.inst_valid(inst_valid),
		.inst(inst),
		.inst_done(inst_done),
		.uop_valid(uop_valid),
		.uop(uop)
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	task automatic add_row(input logic [15:0] word, input int nuop);
		vec_word.push_back(word);
		vec_nuop.push_back(nuop);
		vec_first.push_back(flat_exp.size());
	endtask

	// op, dest, src and pre_step are checked on every uop
	task automatic start_uop(input op_e op, input dest_e dest, input src_e src, input logic pre);
		cur_exp = '0;
		cur_care = '0;
		cur_exp.op = op;
		cur_care.op = op_e'(3'h7);
		cur_exp.dest = dest;
		cur_care.dest = dest_e'(2'h3);
		cur_exp.src = src;
		cur_care.src = src_e'(3'h7);
		cur_exp.pre_step = pre;
		cur_care.pre_step = 1'b1;
	endtask

	task automatic end_uop();
		flat_exp.push_back(cur_exp);
		flat_care.push_back(cur_care);
	endtask

	task automatic expect_addr(input src_e asrc, input addr_op_e aop);
		cur_exp.addr_src = asrc;
		cur_care.addr_src = src_e'(3'h7);
		cur_exp.addr_op = aop;
		cur_care.addr_op = addr_op_e'(1'b1);
	endtask

	task automatic expect_shift(input logic shr, input logic sar, input logic shl,
		input logic [3:0] count);
		cur_exp.use_rotate = 1'b1;
		cur_care.use_rotate = 1'b1;
		cur_exp.use_shr = shr;
		cur_care.use_shr = 1'b1;
		cur_exp.use_sar = sar;
		cur_care.use_sar = 1'b1;
		cur_exp.use_shl = shl;
		cur_care.use_shl = 1'b1;
		cur_exp.rotate_count = count;
		cur_care.rotate_count = 4'hf;
	endtask

	// push of pc+n to [--sp]
	task automatic push_uop(input logic [1:0] n);
		start_uop(op_add, dest_mem, src_imm2, 1'b1);
		cur_exp.addr_reg1 = REG_SP;
		cur_care.addr_reg1 = 4'hf;
		cur_exp.autoincdec = 1'b1;
		cur_care.autoincdec = 1'b1;
		cur_exp.imm2_value = n;
		cur_care.imm2_value = 2'h3;
		end_uop();
	endtask

	`include "decode_vectors.svh"

	// fibonacci lfsr, taps 8 6 5 4
	function automatic logic [7:0] lfsr_step(input logic [7:0] s);
		return {s[6:0], s[7] ^ s[5] ^ s[4] ^ s[3]};
	endfunction

	function automatic int idle_cycles();
		int n;
		lfsr = lfsr_step(lfsr);
		n = lfsr[0];
		lfsr = lfsr_step(lfsr);
		n = 2 * n + lfsr[0];
		return n;
	endfunction

	task automatic check_uop(input uop_t got, input uop_t exp, input uop_t care);
		if (((got ^ exp) & care) != '0) begin
			uop_errs++;
			$display("[ERROR] %0t: uop mismatch, got %h expected %h (care %h)",
				$time, got & care, exp & care, care);
		end
	endtask

	task automatic check_done_count(input int got, input int exp);
		if (got != exp) begin
			count_errs++;
			$display("[ERROR] %0t: inst_done pulses %0d, expected %0d", $time, got, exp);
		end
	endtask

	task automatic check_latency(input int got, input int exp);
		if (got != exp) begin
			stream_errs++;
			$display("[ERROR] %0t: uop out in cycle %0d, expected cycle %0d", $time, got, exp);
		end
	endtask

	// called right after a falling edge, returns after the next one
	task automatic apply_row(input int r);
		int waited;
		inst_valid = 1'b1;
		inst = inst_u'(vec_word[r]);
		done_expected++;
		for (int k = 0; k < vec_nuop[r]; k++) begin
			exp_q.push_back(flat_exp[vec_first[r] + k]);
			care_q.push_back(flat_care[vec_first[r] + k]);
		end
		waited = 0;
		do begin
			@(posedge clk);
			waited++;
		end while (!inst_done && waited < ROW_CYCLES);
		if (!inst_done) begin
			stream_errs++;
			$display("inst_done never came for word %h", vec_word[r]);
		end
		@(negedge clk);
	endtask

	// pre-edge values of the outputs
	always @(posedge clk) begin
		// every valid cycle issues one step
		if (rst_n && inst_valid) begin
			due_q.push_back(cyc_count + UOP_LATENCY);
		end
		if (rst_n && inst_done) begin
			done_count++;
		end
		if (rst_n && uop_valid) begin
			if (exp_q.size() == 0) begin
				stream_errs++;
				$display("unexpected uop %h with nothing left to expect", uop);
			end else begin
				check_uop(uop, exp_q.pop_front(), care_q.pop_front());
			end
			if (due_q.size() != 0) begin
				check_latency(cyc_count, due_q.pop_front());
			end
		end
		cyc_count++;
	end

	initial begin
		int n;
		int drain;
		rst_n = 1'b0;
		inst_valid = 1'b0;
		inst = '0;
		uop_errs = 0;
		count_errs = 0;
		stream_errs = 0;
		done_count = 0;
		done_expected = 0;
		cyc_count = 0;
		lfsr = 8'd53;
		load_vectors();
		repeat (2) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;
		@(negedge clk);
		// random gaps between rows
		for (int r = 0; r < vec_word.size(); r++) begin
			apply_row(r);
			n = idle_cycles();
			if (n > 0) begin
				inst_valid = 1'b0;
				repeat (n) @(negedge clk);
			end
		end
		// back to back stream
		for (int r = 0; r < vec_word.size(); r++) begin
			apply_row(r);
		end
		inst_valid = 1'b0;
		drain = 0;
		while (exp_q.size() != 0 && drain < ROW_CYCLES) begin
			@(negedge clk);
			drain++;
		end
		if (exp_q.size() != 0) begin
			stream_errs++;
			$display("%0d expected uops never came out", exp_q.size());
		end
		// room for stray uops
		repeat (8) @(negedge clk);
		check_done_count(done_count, done_expected);
		$display("errors: uop %0d, count %0d, stream %0d", uop_errs, count_errs, stream_errs);
		if (uop_errs + count_errs + stream_errs == 0) begin
			$display("All checks passed");
		end else begin
			$display("Checks failed");
		end
		$finish;
	end

	// two passes over the table plus reset and drain
	initial begin
		longint limit;
		#1;
		limit = (2 * vec_word.size() + 4) * ROW_CYCLES * CLK_PERIOD;
		#(limit);
		$display("timeout, the decoder stopped making progress");
		$display("Checks failed");
		$finish;
	end

endmodule

`default_nettype wire

// File: verilog.f
+incdir+tests
verilog/isa_pkg.sv
verilog/uop_pkg.sv
verilog/inst_issue.sv
verilog/class_decode.sv
verilog/operand_decode.sv
verilog/uop_build.sv
verilog/inst_decoder.sv
tests/tb_inst_decoder.sv

// File: Bender.yml
package:
  name: inst_decoder

sources:
  - verilog/isa_pkg.sv
  - verilog/uop_pkg.sv
  - verilog/inst_issue.sv
  - verilog/class_decode.sv
  - verilog/operand_decode.sv
  - verilog/uop_build.sv
  - verilog/inst_decoder.sv
  - target: simulation
    include_dirs:
      - tests
    files:
      - tests/tb_inst_decoder.sv
